/* rtl/rv_datapath_pkg.sv */
package rv_datapath_pkg;

    // Data word width, one RV64 register
    localparam int xlen = 64;

    // Instruction word width
    localparam int ilen = 32;

    // Instruction ROM depth in words
    localparam int imem_words = 16;

    // Data memory depth in 64-bit words
    localparam int dmem_words = 32;

    // Store opcode, selects the S-type immediate layout
    localparam logic [6:0] opcode_store = 7'b0100011;

    // Vector types with a fixed meaning
    typedef logic [xlen-1:0] xword_t;
    typedef logic [ilen-1:0] iword_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     imm12_t;
    typedef logic [xlen-1:0] pc_t;

    // Fields sliced out of the instruction register
    // imm12 already holds the S or I layout, not yet extended
    typedef struct packed {
        logic [6:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        imm12_t     imm12;
    } instr_fields_t;

endpackage

/* rtl/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    load_pc,
    output rv_datapath_pkg::pc_t    pc,
    output rv_datapath_pkg::iword_t instruction
);

    // Instruction ROM, one 32-bit word per entry
    rv_datapath_pkg::iword_t rom [rv_datapath_pkg::imem_words];

    // Word index taken from the byte address
    logic [$clog2(rv_datapath_pkg::imem_words)-1:0] rom_idx;

    // Sequential next address, no branches in this datapath
    rv_datapath_pkg::pc_t pc_next;

    // Unused entries read as zero
    // Program image comes from the hex file
    initial begin
        for (int i = 0; i < rv_datapath_pkg::imem_words; i++) begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    // Drop the two byte-offset bits
    assign rom_idx = pc[$clog2(rv_datapath_pkg::imem_words)+1:2];

    assign pc_next = pc + rv_datapath_pkg::pc_t'(4);

    // Program counter
    // Moves only when load_pc is high, otherwise the same word is refetched
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (load_pc) begin
            pc <= pc_next;
        end
    end

    // Instruction register
    // Loads every cycle, so it trails pc by one edge
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            instruction <= '0;
        end else begin
            instruction <= rom[rom_idx];
        end
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      we,
    input  rv_datapath_pkg::reg_idx_t rs1,
    input  rv_datapath_pkg::reg_idx_t rs2,
    input  rv_datapath_pkg::reg_idx_t rd,
    input  rv_datapath_pkg::xword_t   wdata,
    output rv_datapath_pkg::xword_t   rs1_data,
    output rv_datapath_pkg::xword_t   rs2_data
);

    // x0 .. x31
    rv_datapath_pkg::xword_t regs [32];

    // Write port
    // Reset clears every register
    // Writes to x0 are dropped
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Read ports are combinational
    // Index 0 is hard zero regardless of array contents
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
    input  logic                                           CLK,
    input  logic                                           we,
    input  logic [$clog2(rv_datapath_pkg::dmem_words)-1:0] addr,
    input  rv_datapath_pkg::xword_t                        wdata,
    output rv_datapath_pkg::xword_t                        rdata
);

    // Word-addressed storage, no byte lanes
    rv_datapath_pkg::xword_t mem [rv_datapath_pkg::dmem_words];

    // Known contents at time zero
    initial begin
        for (int i = 0; i < rv_datapath_pkg::dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    // Store lands at the edge closing the cycle
    always @(posedge CLK) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Asynchronous read
    assign rdata = mem[addr];

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  rv_datapath_pkg::iword_t        instruction,
    input  rv_datapath_pkg::xword_t        rs1_data,
    input  rv_datapath_pkg::xword_t        rs2_data,
    input  logic                           sub,
    input  logic                           alu_din2_sel,
    output rv_datapath_pkg::instr_fields_t fields,
    output rv_datapath_pkg::xword_t        alu_result
);

    // Immediate after sign extension
    rv_datapath_pkg::xword_t imm_ext;

    // Second ALU operand
    rv_datapath_pkg::xword_t alu_din2;

    // Field slicing
    always_comb begin
        fields.opcode = instruction[6:0];
        fields.rd     = instruction[11:7];
        fields.rs1    = instruction[19:15];
        fields.rs2    = instruction[24:20];
        // Stores split the offset around rs2
        // Everything else keeps it on top
        if (fields.opcode == rv_datapath_pkg::opcode_store) begin
            fields.imm12 = {instruction[31:25], instruction[11:7]};
        end else begin
            fields.imm12 = instruction[31:20];
        end
    end

    // Replicate bit 11 up to the full word
    assign imm_ext = {{(rv_datapath_pkg::xlen - $bits(rv_datapath_pkg::imm12_t))
                       {fields.imm12[11]}}, fields.imm12};

    // Immediate for addi, ld and sd
    // Register for add and sub
    assign alu_din2 = alu_din2_sel ? imm_ext : rs2_data;

    // Adder with subtract control
    always_comb begin
        if (sub) begin
            alu_result = rs1_data - alu_din2;
        end else begin
            alu_result = rs1_data + alu_din2;
        end
    end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                    CLK,
    input  logic                    rst_n,
    // ALU subtract instead of add
    input  logic                    sub,
    // Register file write enable
    input  logic                    we_rf,
    // Data memory write enable
    input  logic                    we_mem,
    // Write-back source, high for ALU, low for memory
    input  logic                    rf_din_sel,
    // Second ALU operand, high for immediate
    input  logic                    alu_din2_sel,
    // Advance the program counter
    input  logic                    load_pc,
    // Observation ports
    output rv_datapath_pkg::pc_t    pc,
    output rv_datapath_pkg::iword_t instruction,
    output rv_datapath_pkg::xword_t alu_result,
    output rv_datapath_pkg::xword_t mem_rdata,
    output rv_datapath_pkg::xword_t wb_data
);

    // Decoded fields from the instruction register
    rv_datapath_pkg::instr_fields_t fields;

    // Register read data
    rv_datapath_pkg::xword_t rs1_data;
    rv_datapath_pkg::xword_t rs2_data;

    // PC, ROM and instruction register
    instruction_fetch i_fetch (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .load_pc     (load_pc),
        .pc          (pc),
        .instruction (instruction)
    );

    // Register indices come straight from the sliced fields
    register_file i_regfile (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .we       (we_rf),
        .rs1      (fields.rs1),
        .rs2      (fields.rs2),
        .rd       (fields.rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Immediate build and add/subtract
    execute_unit i_execute (
        .instruction  (instruction),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .sub          (sub),
        .alu_din2_sel (alu_din2_sel),
        .fields       (fields),
        .alu_result   (alu_result)
    );

    // Low result bits form the word address, rs2 is the store data
    data_memory i_dmem (
        .CLK   (CLK),
        .we    (we_mem),
        .addr  (alu_result[$clog2(rv_datapath_pkg::dmem_words)-1:0]),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    // Write-back select closes the loop into the register file
    assign wb_data = rf_din_sel ? alu_result : mem_rdata;

endmodule

/* bench/tb_datapath.sv */
`timescale 1ns/1ps

module tb_datapath;

    // Run length figures for the cycle limit
    int reset_len   = 4;
    int prog_len    = 10;
    int max_stalls  = 10;
    int cycle_limit;

    // DUT ports
    logic                    CLK;
    logic                    rst_n;
    logic                    sub;
    logic                    we_rf;
    logic                    we_mem;
    logic                    rf_din_sel;
    logic                    alu_din2_sel;
    logic                    load_pc;
    rv_datapath_pkg::pc_t    pc;
    rv_datapath_pkg::iword_t instruction;
    rv_datapath_pkg::xword_t alu_result;
    rv_datapath_pkg::xword_t mem_rdata;
    rv_datapath_pkg::xword_t wb_data;

    // Reference model state
    rv_datapath_pkg::xword_t model_regs [32];
    rv_datapath_pkg::xword_t model_mem [32];
    rv_datapath_pkg::pc_t    exp_pc;
    rv_datapath_pkg::iword_t exp_ir;
    rv_datapath_pkg::xword_t exp_alu;
    rv_datapath_pkg::xword_t exp_mem;
    rv_datapath_pkg::xword_t exp_wb;
    // Program slot held in the instruction register
    // Set to -1 while a zero word is held
    int                      ir_idx;

    // Bookkeeping
    int   cycles;
    int   checks;
    int   errors;
    int   stalls;
    int   x0_runs;
    logic end_stall_done;

    datapath i_datapath (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .sub          (sub),
        .we_rf        (we_rf),
        .we_mem       (we_mem),
        .rf_din_sel   (rf_din_sel),
        .alu_din2_sel (alu_din2_sel),
        .load_pc      (load_pc),
        .pc           (pc),
        .instruction  (instruction),
        .alu_result   (alu_result),
        .mem_rdata    (mem_rdata),
        .wb_data      (wb_data)
    );

    // 100 ns clock
    always #50 CLK = ~CLK;

    // Hung run guard
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the program did not complete within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Hand-assembled test program
    // Slots past the end are zero
    function automatic rv_datapath_pkg::iword_t prog_word(int idx);
        case (idx)
            0: return 32'h00500093;  // addi x1,x0,5
            1: return 32'hFFD00113;  // addi x2,x0,-3
            2: return 32'h002081B3;  // add  x3,x1,x2
            3: return 32'h40208233;  // sub  x4,x1,x2
            4: return 32'h00403423;  // sd   x4,8(x0)
            5: return 32'h00803283;  // ld   x5,8(x0)
            6: return 32'h40100333;  // sub  x6,x0,x1
            7: return 32'h0060B123;  // sd   x6,2(x1)
            8: return 32'h00703383;  // ld   x7,7(x0)
            9: return 32'h00900013;  // addi x0,x0,9
            default: return 32'h0;
        endcase
    endfunction

    // Known ALU result of each program slot
    function automatic rv_datapath_pkg::xword_t alu_fixed(int idx);
        case (idx)
            0: return 64'd5;
            1: return 64'hFFFF_FFFF_FFFF_FFFD;
            2: return 64'd2;
            3, 4, 5: return 64'd8;
            6: return 64'hFFFF_FFFF_FFFF_FFFB;
            7, 8: return 64'd7;
            default: return 64'd9;
        endcase
    endfunction

    // S layout for stores and I layout for everything else
    function automatic rv_datapath_pkg::xword_t imm_value(rv_datapath_pkg::iword_t ir);
        rv_datapath_pkg::imm12_t imm;
        if (ir[6:0] == rv_datapath_pkg::opcode_store) begin
            imm = {ir[31:25], ir[11:7]};
        end else begin
            imm = ir[31:20];
        end
        return {{52{imm[11]}}, imm};
    endfunction

    task automatic check_value(input string name, input rv_datapath_pkg::xword_t expected,
                               input rv_datapath_pkg::xword_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Decoder role
    // Controls follow the opcode of the modelled instruction
    task automatic drive_controls();
        sub          = 1'b0;
        we_rf        = 1'b0;
        we_mem       = 1'b0;
        rf_din_sel   = 1'b1;
        alu_din2_sel = 1'b0;
        case (exp_ir[6:0])
            // addi
            7'b0010011: begin
                we_rf        = 1'b1;
                alu_din2_sel = 1'b1;
            end
            // add or sub
            // funct7 bit 30 picks subtract
            7'b0110011: begin
                we_rf = 1'b1;
                sub   = exp_ir[30];
            end
            // ld
            7'b0000011: begin
                we_rf        = 1'b1;
                alu_din2_sel = 1'b1;
                rf_din_sel   = 1'b0;
            end
            rv_datapath_pkg::opcode_store: begin
                we_mem       = 1'b1;
                alu_din2_sel = 1'b1;
            end
            default: begin
                we_rf = 1'b0;
            end
        endcase
        // One forced stall at the last slot so that addi x0 runs twice
        if (exp_pc == 64'(4 * (prog_len - 1)) && !end_stall_done) begin
            load_pc        = 1'b0;
            end_stall_done = 1'b1;
        end else if (stalls < max_stalls && $urandom_range(3, 0) == 0) begin
            load_pc = 1'b0;
            stalls++;
        end else begin
            load_pc = 1'b1;
        end
    endtask

    task automatic compute_expected();
        rv_datapath_pkg::xword_t op1;
        rv_datapath_pkg::xword_t op2;
        op1 = model_regs[exp_ir[19:15]];
        op2 = alu_din2_sel ? imm_value(exp_ir) : model_regs[exp_ir[24:20]];
        exp_alu = sub ? op1 - op2 : op1 + op2;
        exp_mem = model_mem[exp_alu[4:0]];
        exp_wb  = rf_din_sel ? exp_alu : exp_mem;
    endtask

    task automatic check_cycle();
        check_value("pc", exp_pc, pc);
        check_value("instruction", 64'(exp_ir), 64'(instruction));
        check_value("alu_result", exp_alu, alu_result);
        check_value("mem_rdata", exp_mem, mem_rdata);
        check_value("wb_data", exp_wb, wb_data);
        if (ir_idx >= 0) begin
            check_value("program_alu", alu_fixed(ir_idx), alu_result);
        end
        // Loads bring back what the stores left
        if (ir_idx == 5) begin
            check_value("ld_x5", 64'd8, wb_data);
        end
        if (ir_idx == 8) begin
            check_value("ld_x7", 64'hFFFF_FFFF_FFFF_FFFB, wb_data);
        end
        // x0 still reads zero after the write attempt
        if (ir_idx == 9 && x0_runs > 0) begin
            check_value("x0_read", 64'd9, alu_result);
        end
    endtask

    // State change at the closing edge
    task automatic advance_model();
        // Store data is read before any register write of the same cycle
        if (we_mem) begin
            model_mem[exp_alu[4:0]] = model_regs[exp_ir[24:20]];
        end
        if (we_rf && exp_ir[11:7] != 5'd0) begin
            model_regs[exp_ir[11:7]] = exp_wb;
        end
        if (ir_idx == 9) begin
            x0_runs++;
        end
        // Instruction register takes the word at the current pc
        exp_ir = prog_word(int'(exp_pc >> 2));
        if (exp_pc < 64'(4 * prog_len)) begin
            ir_idx = int'(exp_pc >> 2);
        end else begin
            ir_idx = -1;
        end
        if (load_pc) begin
            exp_pc = exp_pc + 64'd4;
        end
    endtask

    initial begin
        void'($urandom(32'h52131cd2));
        cycle_limit    = 8 * (reset_len + prog_len + max_stalls + 1);
        CLK            = 1'b0;
        rst_n          = 1'b0;
        sub            = 1'b0;
        we_rf          = 1'b0;
        we_mem         = 1'b0;
        rf_din_sel     = 1'b0;
        alu_din2_sel   = 1'b0;
        load_pc        = 1'b0;
        cycles         = 0;
        checks         = 0;
        errors         = 0;
        stalls         = 0;
        x0_runs        = 0;
        end_stall_done = 1'b0;
        exp_pc         = '0;
        exp_ir         = '0;
        ir_idx         = -1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            model_mem[i]  = '0;
        end

        // State is cleared well before the last reset edge
        repeat (reset_len - 1) @(posedge CLK);
        @(negedge CLK);
        check_value("reset_pc", '0, pc);
        check_value("reset_instruction", '0, 64'(instruction));
        @(posedge CLK);
        #1;
        rst_n = 1'b1;

        // One instruction register slot per pass
        while (x0_runs < 2) begin
            drive_controls();
            @(negedge CLK);
            compute_expected();
            check_cycle();
            advance_model();
            @(posedge CLK);
            #1;
        end

        $display("Checks: %0d, errors: %0d, stalls: %0d", checks, errors, stalls);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* mini_rv64_datapath.f */
rtl/rv_datapath_pkg.sv
rtl/instruction_fetch.sv
rtl/register_file.sv
rtl/data_memory.sv
rtl/execute_unit.sv
rtl/datapath.sv
bench/tb_datapath.sv

/* Bender.yml */
package:
  name: mini_rv64_datapath

dependencies: {}

sources:
  # Package first, the RTL modules refer to it by scoped names
  - rtl/rv_datapath_pkg.sv
  # Leaf modules
  - rtl/instruction_fetch.sv
  - rtl/register_file.sv
  - rtl/data_memory.sv
  - rtl/execute_unit.sv
  # Top level
  - rtl/datapath.sv
  # Testbench
  - target: test
    files:
      - bench/tb_datapath.sv

/* program.hex */
// One 32-bit instruction word per line, starting at word address 0
00500093
FFD00113
002081B3
40208233
00403423
00803283
40100333
0060B123
00703383
00900013
